/* common/axi_bridge_pkg.sv */
//======================================
// Field widths, burst codes and response
// codes shared by the write bridge RTL and
// its testbench
//======================================

package axi_bridge_pkg;

  //======================================
  // Channel field widths
  //======================================
  localparam int AXI_LEN_W   = 8;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_RESP_W  = 2;
  localparam int AXI_PROT_W  = 3;

  //======================================
  // Burst types
  //======================================
  // WRAP is not handled by the bridge
  localparam logic [AXI_BURST_W-1:0] BURST_FIXED = 2'd0;
  localparam logic [AXI_BURST_W-1:0] BURST_INCR  = 2'd1;

  //======================================
  // Response codes
  //======================================
  // Ordered by severity, so a larger code wins when merging
  localparam logic [AXI_RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [AXI_RESP_W-1:0] RESP_EXOKAY = 2'd1;
  localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'd2;
  localparam logic [AXI_RESP_W-1:0] RESP_DECERR = 2'd3;

endpackage

/* write_split/aw_burst_splitter.sv */
//======================================
// Splits an AXI4 write burst into single
// AXI4-Lite address beats and pushes one
// burst record per accepted burst
//======================================

`timescale 1ns/1ps

module aw_burst_splitter #(
  parameter int ADDR_W = 32,
  parameter int ID_W   = 4
) (
  input  logic                               clk,
  input  logic                               rstn,
  // AXI4 write address, master side
  input  logic                               s_aw_valid,
  output logic                               s_aw_ready,
  input  logic [ID_W-1:0]                    s_aw_id,
  input  logic [ADDR_W-1:0]                  s_aw_addr,
  input  logic [axi_bridge_pkg::AXI_LEN_W-1:0]   s_aw_len,
  input  logic [axi_bridge_pkg::AXI_SIZE_W-1:0]  s_aw_size,
  input  logic [axi_bridge_pkg::AXI_BURST_W-1:0] s_aw_burst,
  input  logic [axi_bridge_pkg::AXI_PROT_W-1:0]  s_aw_prot,
  // AXI4-Lite write address, slave side
  output logic                               m_aw_valid,
  input  logic                               m_aw_ready,
  output logic [ADDR_W-1:0]                  m_aw_addr,
  output logic [axi_bridge_pkg::AXI_PROT_W-1:0]  m_aw_prot,
  // Burst record FIFO write side
  output logic                               rec_push,
  input  logic                               rec_full,
  output logic [ID_W-1:0]                    rec_id,
  output logic [axi_bridge_pkg::AXI_LEN_W-1:0]   rec_len
);

  import axi_bridge_pkg::*;

  localparam logic ST_IDLE  = 1'b0;
  localparam logic ST_ISSUE = 1'b1;

  logic                   state;
  logic [AXI_LEN_W-1:0]   beats_left;
  logic [ADDR_W-1:0]      beat_addr;
  logic [ADDR_W-1:0]      beat_step;
  logic [AXI_SIZE_W-1:0]  beat_size;
  logic [AXI_BURST_W-1:0] burst_type;
  logic [AXI_PROT_W-1:0]  burst_prot;
  logic [ADDR_W-1:0]      addr_aligned;
  logic [ADDR_W-1:0]      addr_next;
  logic                   aw_accept;
  logic                   beat_done;

  assign s_aw_ready = (state == ST_IDLE) && !rec_full;
  assign aw_accept  = s_aw_valid && s_aw_ready;
  assign beat_done  = m_aw_valid && m_aw_ready;

  // Record leaves on the same edge the burst is accepted
  assign rec_push = aw_accept;
  assign rec_id   = s_aw_id;
  assign rec_len  = s_aw_len;

  assign m_aw_valid = (state == ST_ISSUE);
  assign m_aw_addr  = beat_addr;
  assign m_aw_prot  = burst_prot;

  // INCR steps from the size-aligned address, FIXED repeats the start
  assign addr_aligned = beat_addr & ({ADDR_W{1'b1}} << beat_size);
  assign addr_next    = (burst_type == BURST_INCR) ? addr_aligned + beat_step : beat_addr;

  //======================================
  // Control FSM and beat counter
  //======================================
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state      <= ST_IDLE;
      beats_left <= '0;
    end
    else if (aw_accept)
    begin
      state      <= ST_ISSUE;
      beats_left <= s_aw_len;
    end
    else if (beat_done)
    begin
      if (beats_left == '0)
      begin
        state <= ST_IDLE;
      end
      else
      begin
        beats_left <= beats_left - AXI_LEN_W'(1);
      end
    end
  end

  // Burst payload, loaded at acceptance
  always_ff @(posedge clk)
  begin
    if (aw_accept)
    begin
      beat_addr  <= s_aw_addr;
      beat_step  <= ADDR_W'(1) << s_aw_size;
      beat_size  <= s_aw_size;
      burst_type <= s_aw_burst;
      burst_prot <= s_aw_prot;
    end
    else if (beat_done)
    begin
      beat_addr <= addr_next;
    end
  end

endmodule

/* verilog/sync_fifo.sv */
//======================================
// Synchronous FIFO, one entry per record
// DEPTH must be a power of two
//======================================

`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             push,
  input  logic [WIDTH-1:0] wdata,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] rdata,
  output logic             empty
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  // Extra top bit tells a full buffer from an empty one
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign rdata = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr[PTR_W-1:0]] <= wdata;
    end
  end

endmodule

/* resp_merge/b_resp_merger.sv */
//======================================
// Gathers the Lite write responses of one
// burst into a single AXI4 write response
//======================================

`timescale 1ns/1ps

module b_resp_merger #(
  parameter int ID_W = 4
) (
  input  logic                                 clk,
  input  logic                                 rstn,
  // AXI4-Lite write response, slave side
  input  logic                                 m_b_valid,
  output logic                                 m_b_ready,
  input  logic [axi_bridge_pkg::AXI_RESP_W-1:0] m_b_resp,
  // AXI4 write response, master side
  output logic                                 s_b_valid,
  input  logic                                 s_b_ready,
  output logic [ID_W-1:0]                      s_b_id,
  output logic [axi_bridge_pkg::AXI_RESP_W-1:0] s_b_resp,
  // Burst record FIFO read side
  input  logic [ID_W-1:0]                      rec_id,
  input  logic [axi_bridge_pkg::AXI_LEN_W-1:0]  rec_len,
  input  logic                                 rec_empty,
  output logic                                 rec_pop
);

  import axi_bridge_pkg::*;

  // One bit wider than len so a 256 beat burst still counts
  logic [AXI_LEN_W:0]    beat_cnt;
  logic [AXI_RESP_W-1:0] worst_resp;
  logic [AXI_RESP_W-1:0] resp_max;
  logic                  lite_beat;
  logic                  last_beat;
  logic                  b_taken;

  // Accept Lite responses only for a known burst and not while a merged one waits
  assign m_b_ready = !rec_empty && !s_b_valid;
  assign lite_beat = m_b_valid && m_b_ready;
  assign b_taken   = s_b_valid && s_b_ready;

  assign last_beat = (beat_cnt == {1'b0, rec_len});
  assign resp_max  = (m_b_resp > worst_resp) ? m_b_resp : worst_resp;

  assign s_b_id   = rec_id;
  assign s_b_resp = worst_resp;
  assign rec_pop  = b_taken;

  //======================================
  // Beat count and severity tracking
  //======================================
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      beat_cnt   <= '0;
      worst_resp <= RESP_OKAY;
      s_b_valid  <= 1'b0;
    end
    else if (b_taken)
    begin
      beat_cnt   <= '0;
      worst_resp <= RESP_OKAY;
      s_b_valid  <= 1'b0;
    end
    else if (lite_beat)
    begin
      beat_cnt   <= beat_cnt + 1'b1;
      worst_resp <= resp_max;
      if (last_beat)
      begin
        s_b_valid <= 1'b1;
      end
    end
  end

endmodule

/* verilog/axi4_write_bridge.sv */
//======================================
// AXI4 to AXI4-Lite write bridge top level
// Splitter feeds a burst record FIFO that
// the response merger drains in order
//======================================

`timescale 1ns/1ps

module axi4_write_bridge #(
  parameter int ADDR_W      = 32,
  parameter int DATA_W      = 32,
  parameter int ID_W        = 4,
  parameter int BURST_DEPTH = 4
) (
  input  logic                                   clk,
  input  logic                                   rstn,
  // AXI4 slave port
  input  logic                                   s_aw_valid,
  output logic                                   s_aw_ready,
  input  logic [ID_W-1:0]                        s_aw_id,
  input  logic [ADDR_W-1:0]                      s_aw_addr,
  input  logic [axi_bridge_pkg::AXI_LEN_W-1:0]   s_aw_len,
  input  logic [axi_bridge_pkg::AXI_SIZE_W-1:0]  s_aw_size,
  input  logic [axi_bridge_pkg::AXI_BURST_W-1:0] s_aw_burst,
  input  logic [axi_bridge_pkg::AXI_PROT_W-1:0]  s_aw_prot,
  input  logic                                   s_w_valid,
  output logic                                   s_w_ready,
  input  logic [DATA_W-1:0]                      s_w_data,
  input  logic [DATA_W/8-1:0]                    s_w_strb,
  input  logic                                   s_w_last,
  output logic                                   s_b_valid,
  input  logic                                   s_b_ready,
  output logic [ID_W-1:0]                        s_b_id,
  output logic [axi_bridge_pkg::AXI_RESP_W-1:0]  s_b_resp,
  // AXI4-Lite master port
  output logic                                   m_aw_valid,
  input  logic                                   m_aw_ready,
  output logic [ADDR_W-1:0]                      m_aw_addr,
  output logic [axi_bridge_pkg::AXI_PROT_W-1:0]  m_aw_prot,
  output logic                                   m_w_valid,
  input  logic                                   m_w_ready,
  output logic [DATA_W-1:0]                      m_w_data,
  output logic [DATA_W/8-1:0]                    m_w_strb,
  input  logic                                   m_b_valid,
  output logic                                   m_b_ready,
  input  logic [axi_bridge_pkg::AXI_RESP_W-1:0]  m_b_resp
);

  import axi_bridge_pkg::*;

  localparam int REC_W = ID_W + AXI_LEN_W;

  logic                 rec_push;
  logic                 rec_full;
  logic [ID_W-1:0]      push_id;
  logic [AXI_LEN_W-1:0] push_len;
  logic [REC_W-1:0]     head_rec;
  logic                 rec_pop;
  logic                 rec_empty;

  // W beats go straight through, each one pairs with a Lite address beat
  assign m_w_valid = s_w_valid;
  assign m_w_data  = s_w_data;
  assign m_w_strb  = s_w_strb;
  assign s_w_ready = m_w_ready;

  aw_burst_splitter #(
    .ADDR_W (ADDR_W),
    .ID_W   (ID_W)
  ) u_splitter (
    .clk        (clk),
    .rstn       (rstn),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_aw_id    (s_aw_id),
    .s_aw_addr  (s_aw_addr),
    .s_aw_len   (s_aw_len),
    .s_aw_size  (s_aw_size),
    .s_aw_burst (s_aw_burst),
    .s_aw_prot  (s_aw_prot),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_aw_addr  (m_aw_addr),
    .m_aw_prot  (m_aw_prot),
    .rec_push   (rec_push),
    .rec_full   (rec_full),
    .rec_id     (push_id),
    .rec_len    (push_len)
  );

  // Record layout is ID above length
  sync_fifo #(
    .WIDTH (REC_W),
    .DEPTH (BURST_DEPTH)
  ) u_burst_fifo (
    .clk   (clk),
    .rstn  (rstn),
    .push  (rec_push),
    .wdata ({push_id, push_len}),
    .full  (rec_full),
    .pop   (rec_pop),
    .rdata (head_rec),
    .empty (rec_empty)
  );

  b_resp_merger #(
    .ID_W (ID_W)
  ) u_merger (
    .clk       (clk),
    .rstn      (rstn),
    .m_b_valid (m_b_valid),
    .m_b_ready (m_b_ready),
    .m_b_resp  (m_b_resp),
    .s_b_valid (s_b_valid),
    .s_b_ready (s_b_ready),
    .s_b_id    (s_b_id),
    .s_b_resp  (s_b_resp),
    .rec_id    (head_rec[REC_W-1:AXI_LEN_W]),
    .rec_len   (head_rec[AXI_LEN_W-1:0]),
    .rec_empty (rec_empty),
    .rec_pop   (rec_pop)
  );

endmodule

/* test/bridge_props.sv */
//========================================
// Channel stability checks, bound into the
// write bridge top level
//========================================

`timescale 1ns/1ps

module bridge_props #(
  parameter int ADDR_W = 32,
  parameter int ID_W   = 4
) (
  input logic              clk,
  input logic              rstn,
  input logic              s_aw_valid,
  input logic              s_aw_ready,
  input logic              m_aw_valid,
  input logic              m_aw_ready,
  input logic [ADDR_W-1:0] m_aw_addr,
  input logic              s_b_valid,
  input logic              s_b_ready,
  input logic [ID_W-1:0]   s_b_id
);

  // A stalled Lite address beat keeps valid and address
  assert property (@(posedge clk) disable iff (!rstn)
    m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw_addr))
  else $error("m_aw changed while stalled");

  assert property (@(posedge clk) disable iff (!rstn)
    s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b_id))
  else $error("s_b changed while stalled");

  // An accepted burst is issued from the next clock with no new burst taken
  assert property (@(posedge clk) disable iff (!rstn)
    s_aw_valid && s_aw_ready |=> m_aw_valid && !s_aw_ready)
  else $error("accepted burst did not start issuing");

endmodule

bind axi4_write_bridge bridge_props #(
  .ADDR_W (ADDR_W),
  .ID_W   (ID_W)
) u_props (
  .clk        (clk),
  .rstn       (rstn),
  .s_aw_valid (s_aw_valid),
  .s_aw_ready (s_aw_ready),
  .m_aw_valid (m_aw_valid),
  .m_aw_ready (m_aw_ready),
  .m_aw_addr  (m_aw_addr),
  .s_b_valid  (s_b_valid),
  .s_b_ready  (s_b_ready),
  .s_b_id     (s_b_id)
);

/* test/tb_axi4_write_bridge.sv */
//========================================
// Directed testbench for the AXI4 to AXI4-Lite
// write bridge, with a small Lite slave model
//========================================

`timescale 1ns/1ps

module tb_axi4_write_bridge;

  import axi_bridge_pkg::*;

  localparam int TIMEOUT = 200;

  logic                   clk;
  logic                   rstn;
  logic                   s_aw_valid;
  logic                   s_aw_ready;
  logic [3:0]             s_aw_id;
  logic [31:0]            s_aw_addr;
  logic [AXI_LEN_W-1:0]   s_aw_len;
  logic [AXI_SIZE_W-1:0]  s_aw_size;
  logic [AXI_BURST_W-1:0] s_aw_burst;
  logic [AXI_PROT_W-1:0]  s_aw_prot;
  logic                   s_w_valid;
  logic                   s_w_ready;
  logic [31:0]            s_w_data;
  logic [3:0]             s_w_strb;
  logic                   s_w_last;
  logic                   s_b_valid;
  logic                   s_b_ready;
  logic [3:0]             s_b_id;
  logic [AXI_RESP_W-1:0]  s_b_resp;
  logic                   m_aw_valid;
  logic                   m_aw_ready;
  logic [31:0]            m_aw_addr;
  logic [AXI_PROT_W-1:0]  m_aw_prot;
  logic                   m_w_valid;
  logic                   m_w_ready;
  logic [31:0]            m_w_data;
  logic [3:0]             m_w_strb;
  logic                   m_b_valid;
  logic                   m_b_ready;
  logic [AXI_RESP_W-1:0]  m_b_resp;

  // Lite slave model state
  logic [AXI_RESP_W-1:0]  resp_plan [32];
  logic [31:0]            aw_addr_q [$];
  logic [AXI_PROT_W-1:0]  aw_prot_q [$];
  logic [31:0]            w_data_q [$];
  logic [3:0]             w_strb_q [$];
  int                     b_done;
  bit                     b_hs;
  bit                     stall_en;
  int                     seed;
  int                     rnd;
  int                     errors;

  axi4_write_bridge u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //========================================
  // Lite slave model
  //========================================
  // Handshakes are logged mid-cycle, where every signal has settled
  always @(negedge clk)
  begin
    if (rstn)
    begin
      if (m_aw_valid && m_aw_ready)
      begin
        aw_addr_q.push_back(m_aw_addr);
        aw_prot_q.push_back(m_aw_prot);
      end
      if (m_w_valid && m_w_ready)
      begin
        w_data_q.push_back(m_w_data);
        w_strb_q.push_back(m_w_strb);
      end
      if (m_b_valid && m_b_ready)
      begin
        b_done = b_done + 1;
        b_hs = 1'b1;
      end
    end
  end

  // One response per beat, once both its address and data have arrived
  always @(posedge clk)
  begin
    #1;
    rnd = $random(seed);
    m_aw_ready = stall_en ? rnd[0] : 1'b1;
    if (b_hs)
    begin
      m_b_valid = 1'b0;
      b_hs = 1'b0;
    end
    else if (!m_b_valid && b_done < aw_addr_q.size() && b_done < w_data_q.size())
    begin
      m_b_valid = 1'b1;
      m_b_resp = resp_plan[b_done];
    end
  end

  //========================================
  // Helpers
  //========================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic clear_logs();
    aw_addr_q.delete();
    aw_prot_q.delete();
    w_data_q.delete();
    w_strb_q.delete();
    b_done = 0;
    foreach (resp_plan[i])
    begin
      resp_plan[i] = RESP_OKAY;
    end
  endtask

  // Called just after a clock edge, like every driving task here
  task automatic send_aw(input logic [3:0] id, input logic [31:0] addr,
                         input logic [7:0] len, input logic [2:0] size,
                         input logic [1:0] burst, input logic [2:0] prot);
    int t;
    s_aw_id = id;
    s_aw_addr = addr;
    s_aw_len = len;
    s_aw_size = size;
    s_aw_burst = burst;
    s_aw_prot = prot;
    s_aw_valid = 1'b1;
    t = 0;
    // s_aw_ready comes from registers, so its value now holds at the next edge
    while (!s_aw_ready && t < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!s_aw_ready)
    begin
      errors++;
      $display("Timeout: burst with ID %0h was never accepted", id);
    end
    @(posedge clk);
    #1;
    s_aw_valid = 1'b0;
  endtask

  task automatic send_w(input int beats, input logic [31:0] base, input logic [3:0] strb);
    int t;
    for (int i = 0; i < beats; i++)
    begin
      s_w_data = base ^ (i * 32'h0101_0101);
      s_w_strb = strb;
      s_w_last = (i == beats - 1);
      s_w_valid = 1'b1;
      t = 0;
      while (!s_w_ready && t < TIMEOUT)
      begin
        @(posedge clk);
        #1;
        t++;
      end
      if (!s_w_ready)
      begin
        errors++;
        $display("Timeout: write data beat %0d was never taken", i);
      end
      @(posedge clk);
      #1;
    end
    s_w_valid = 1'b0;
    s_w_last = 1'b0;
  endtask

  task automatic wait_b(input logic [3:0] id, input logic [1:0] resp);
    int t;
    t = 0;
    while (!s_b_valid && t < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!s_b_valid)
    begin
      errors++;
      $display("Timeout: no write response for burst ID %0h", id);
    end
    else
    begin
      check_value("s_b_id", s_b_id, id);
      check_value("s_b_resp", s_b_resp, resp);
      s_b_ready = 1'b1;
      @(posedge clk);
      #1;
      s_b_ready = 0;
    end
  endtask

  // Expected addresses follow the burst rules, start taken as size aligned
  task automatic check_lite_beats(input int first, input logic [31:0] addr,
                                  input int len, input logic [2:0] size,
                                  input logic [1:0] burst, input logic [2:0] prot);
    logic [31:0] exp;
    if (aw_addr_q.size() < first + len + 1)
    begin
      errors++;
      $display("Lite side saw only %0d address beats", aw_addr_q.size());
    end
    else
    begin
      for (int i = 0; i <= len; i++)
      begin
        exp = (burst == BURST_INCR) ? addr + i * (32'd1 << size) : addr;
        check_value("m_aw_addr", aw_addr_q[first + i], exp);
        check_value("m_aw_prot", aw_prot_q[first + i], prot);
      end
    end
  endtask

  task automatic check_no_extra_b();
    repeat (5)
    begin
      @(posedge clk);
      #1;
      check_value("s_b_valid", s_b_valid, 1'b0);
    end
  endtask

  //========================================
  // Directed tests
  //========================================
  task automatic check_reset_state();
    check_value("s_b_valid", s_b_valid, 1'b0);
    check_value("m_aw_valid", m_aw_valid, 1'b0);
    check_value("s_aw_ready", s_aw_ready, 1'b1);
  endtask

  task automatic run_single_write();
    clear_logs();
    send_aw(4'h3, 32'h0000_1000, 8'd0, 3'd2, BURST_INCR, 3'b010);
    send_w(1, 32'hCAFE_0001, 4'h5);
    wait_b(4'h3, RESP_OKAY);
    check_value("m_aw beat count", aw_addr_q.size(), 1);
    check_lite_beats(0, 32'h0000_1000, 0, 3'd2, BURST_INCR, 3'b010);
    check_value("m_w_data", w_data_q[0], 32'hCAFE_0001);
    check_value("m_w_strb", w_strb_q[0], 4'h5);
    check_no_extra_b();
  endtask

  task automatic run_incr_burst();
    clear_logs();
    send_aw(4'h5, 32'h0000_2000, 8'd3, 3'd2, BURST_INCR, 3'b000);
    send_w(4, 32'h1111_0000, 4'hF);
    wait_b(4'h5, RESP_OKAY);
    check_value("m_b beat count", b_done, 4);
    check_value("m_aw beat count", aw_addr_q.size(), 4);
    check_lite_beats(0, 32'h0000_2000, 3, 3'd2, BURST_INCR, 3'b000);
    check_no_extra_b();
  endtask

  task automatic run_fixed_burst();
    clear_logs();
    send_aw(4'h6, 32'h0000_3004, 8'd2, 3'd2, BURST_FIXED, 3'b001);
    send_w(3, 32'h2222_0000, 4'hF);
    wait_b(4'h6, RESP_OKAY);
    check_value("m_aw beat count", aw_addr_q.size(), 3);
    check_lite_beats(0, 32'h0000_3004, 2, 3'd2, BURST_FIXED, 3'b001);
  endtask

  task automatic run_error_merge();
    clear_logs();
    resp_plan[2] = RESP_SLVERR;
    send_aw(4'h9, 32'h0000_4000, 8'd3, 3'd2, BURST_INCR, 3'b000);
    send_w(4, 32'h3333_0000, 4'hF);
    wait_b(4'h9, RESP_SLVERR);
  endtask

  task automatic run_back_to_back();
    clear_logs();
    stall_en = 1'b1;
    send_aw(4'h1, 32'h0000_5000, 8'd3, 3'd2, BURST_INCR, 3'b001);
    send_aw(4'hA, 32'h0000_6008, 8'd2, 3'd2, BURST_FIXED, 3'b010);
    send_w(7, 32'h4444_0000, 4'hF);
    wait_b(4'h1, RESP_OKAY);
    wait_b(4'hA, RESP_OKAY);
    stall_en = 1'b0;
    check_value("m_b beat count", b_done, 7);
    check_value("m_aw beat count", aw_addr_q.size(), 7);
    check_lite_beats(0, 32'h0000_5000, 3, 3'd2, BURST_INCR, 3'b001);
    check_lite_beats(4, 32'h0000_6008, 2, 3'd2, BURST_FIXED, 3'b010);
  endtask

  initial
  begin
    seed = 32'h7dea5d4d;
    errors = 0;
    rstn = 1'b0;
    s_aw_valid = 1'b0;
    s_aw_id = '0;
    s_aw_addr = '0;
    s_aw_len = '0;
    s_aw_size = '0;
    s_aw_burst = BURST_INCR;
    s_aw_prot = '0;
    s_w_valid = 1'b0;
    s_w_data = '0;
    s_w_strb = '0;
    s_w_last = 1'b0;
    s_b_ready = 1'b0;
    m_aw_ready = 1'b1;
    m_w_ready = 1'b1;
    m_b_valid = 1'b0;
    m_b_resp = RESP_OKAY;
    stall_en = 1'b0;
    b_hs = 1'b0;
    clear_logs();
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;

    check_reset_state();
    run_single_write();
    run_incr_burst();
    run_fixed_burst();
    run_error_merge();
    run_back_to_back();

    $display("Checks complete with %0d error(s)", errors);
    if (errors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/axi_bridge_pkg.sv
write_split/aw_burst_splitter.sv
verilog/sync_fifo.sv
resp_merge/b_resp_merger.sv
verilog/axi4_write_bridge.sv
test/bridge_props.sv
test/tb_axi4_write_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the write bridge testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi4_write_bridge \
  -f filelist.f

./obj_dir/Vtb_axi4_write_bridge | tee sim.log

if grep -q "all tests passed" sim.log; then
  echo "Simulation result: ok"
else
  echo "Simulation result: failure, see sim.log"
  exit 1
fi
